//--- logic/narrow_pkg.sv
/* shared types and limits for the wide-to-narrow bus adapter.
   logic files reach these by scoped name. */

`default_nettype none

package narrow_pkg;

	// ####################
	// limits
	// ####################

	localparam int MAX_ARCHBITSZ = 256; // widest cpu word the lane index logic covers.

	// ####################
	// types
	// ####################

	// one lane of the cpu word, and also the whole narrow data bus.
	typedef logic [7:0] byte_t;

	// lane walker sequencing.
	typedef enum logic [1:0] {
		IDLE  = 2'd0, // waiting for a request strobe.
		ISSUE = 2'd1, // one byte access per clock.
		DRAIN = 2'd2  // last read byte lands, done follows.
	} walker_state_e;

endpackage

`default_nettype wire

//--- logic/byte_addr.sv
/* turns a word address and a lane select mask into the byte address
   of the lowest selected lane. purely combinational. */

`default_nettype none

module byte_addr #(
	parameter int ARCHBITSZ = 32,
	localparam int SELW = ARCHBITSZ / 8, // one select bit per byte lane.
	localparam int LANEW = $clog2(SELW), // bits needed for a lane index.
	localparam int ADDRW = ARCHBITSZ - LANEW // word address width.
) (
	input  logic [ADDRW-1:0] addr_i, // word address.
	input  logic [SELW-1:0] sel_i, // lanes still wanted.
	output logic [ARCHBITSZ-1:0] addr_o // full byte address.
);

	// ####################
	// width check
	// ####################

	if (ARCHBITSZ < 16 || ARCHBITSZ > narrow_pkg::MAX_ARCHBITSZ) begin : g_bad_width
		$error("byte_addr: ARCHBITSZ %0d outside 16..%0d",
			ARCHBITSZ, narrow_pkg::MAX_ARCHBITSZ);
	end

	// ####################
	// lowest set lane
	// ####################

	logic [LANEW-1:0] lane; // index of the lowest set select bit.

	// scan from the top down so the lowest set bit is written last.
	// an empty mask leaves lane at zero.
	always_comb begin
		lane = '0;
		for (int i = SELW - 1; i >= 0; i--) begin
			if (sel_i[i]) begin
				lane = LANEW'(i); // lower lanes overwrite higher ones.
			end
		end
	end

	assign addr_o = {addr_i, lane}; // word address on top, lane in the low bits.

endmodule

`default_nettype wire

//--- logic/lane_walker.sv
/* walks the selected lanes of one cpu word request, one byte access per
   clock on the narrow bus, and rebuilds the read word lane by lane. */

`default_nettype none

module lane_walker #(
	parameter int ARCHBITSZ = 32,
	localparam int SELW = ARCHBITSZ / 8, // byte lanes per word.
	localparam int LANEW = $clog2(SELW), // lane index width.
	localparam int ADDRW = ARCHBITSZ - LANEW // word address width.
) (
	input  logic clk_i,
	input  logic reset_i,
	input  logic req_i, // single cycle request strobe.
	input  logic we_i, // 1 write, 0 read.
	input  logic [ADDRW-1:0] waddr_i, // word address.
	input  logic [SELW-1:0] sel_i, // byte lane mask.
	input  logic [ARCHBITSZ-1:0] wdata_i,
	output logic busy_o,
	output logic done_o, // single cycle completion strobe.
	output logic [ARCHBITSZ-1:0] rdata_o,
	output logic [SELW-1:0] pend_o, // lanes not issued yet.
	output logic [ADDRW-1:0] waddr_o, // captured word address.
	input  logic [ARCHBITSZ-1:0] baddr_i, // lowest pending byte address.
	output logic bstb_o, // narrow bus strobe.
	output logic bwe_o,
	output logic [ARCHBITSZ-1:0] baddr_o,
	output narrow_pkg::byte_t bwdata_o,
	input  narrow_pkg::byte_t brdata_i // valid the cycle after a read strobe.
);

	// ####################
	// state
	// ####################

	narrow_pkg::walker_state_e state_q;
	logic [SELW-1:0] pend_q; // lanes still to issue.
	logic [ADDRW-1:0] waddr_q;
	logic we_q;
	logic [ARCHBITSZ-1:0] wdata_q;
	logic [ARCHBITSZ-1:0] result_q; // read word being rebuilt.
	logic done_q;
	logic rd_vld_q; // a read byte arrives this cycle.
	logic [LANEW-1:0] rd_lane_q; // lane that byte belongs to.

	logic take; // request accepted on this edge.
	logic [LANEW-1:0] lane; // lane issued this cycle.
	logic [SELW-1:0] pend_left; // mask after this cycle's lane.

	assign take = req_i && (state_q == narrow_pkg::IDLE);
	assign lane = baddr_i[LANEW-1:0]; // low bits of the byte address are the lane.
	assign pend_left = pend_q & ~(SELW'(1) << lane);

	// ####################
	// control
	// ####################

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_q <= narrow_pkg::IDLE;
			pend_q <= '0;
			done_q <= 1'b0;
			rd_vld_q <= 1'b0;
		end else begin
			done_q <= 1'b0; // strobe, one cycle only.
			rd_vld_q <= bstb_o && !we_q; // ram answers one cycle later.
			unique case (state_q)
				narrow_pkg::IDLE: begin
					if (req_i) begin
						pend_q <= sel_i;
						if (sel_i == '0) begin
							state_q <= narrow_pkg::DRAIN; // nothing to move.
						end else begin
							state_q <= narrow_pkg::ISSUE;
						end
					end
				end
				narrow_pkg::ISSUE: begin
					pend_q <= pend_left; // retire the lane just sent.
					if (pend_left == '0) begin
						state_q <= narrow_pkg::DRAIN;
					end
				end
				narrow_pkg::DRAIN: begin
					done_q <= 1'b1; // last byte is in, report next cycle.
					state_q <= narrow_pkg::IDLE;
				end
				default: begin
					state_q <= narrow_pkg::IDLE;
				end
			endcase
		end
	end

	// ####################
	// datapath
	// ####################

	// request payload and the lane of each issued access.
	always_ff @(posedge clk_i) begin
		if (take) begin
			waddr_q <= waddr_i;
			we_q <= we_i;
			wdata_q <= wdata_i;
		end
		if (bstb_o) begin
			rd_lane_q <= lane; // remembered for the returning byte.
		end
	end

	// unselected lanes stay zero from the clear at request time.
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			result_q <= '0;
		end else if (take) begin
			result_q <= '0;
		end else if (rd_vld_q) begin
			result_q[rd_lane_q*8 +: 8] <= brdata_i; // byte back into its own lane.
		end
	end

	assign busy_o = (state_q != narrow_pkg::IDLE);
	assign done_o = done_q;
	assign rdata_o = result_q; // held until the next request clears it.
	assign pend_o = pend_q;
	assign waddr_o = waddr_q;
	assign bstb_o = (state_q == narrow_pkg::ISSUE); // pend is never empty here.
	assign bwe_o = bstb_o && we_q;
	assign baddr_o = baddr_i;
	assign bwdata_o = wdata_q[lane*8 +: 8]; // write byte of the lane on the bus.

	// ####################
	// checks
	// ####################

	// upstream must wait for done before the next strobe.
	a_no_req_busy: assert property (@(posedge clk_i) disable iff (reset_i)
		busy_o |-> !req_i)
		else $error("lane_walker: req_i while busy_o high");

	// every strobe carries a lane that is still pending.
	a_stb_pend: assert property (@(posedge clk_i) disable iff (reset_i)
		bstb_o |-> (pend_q != '0))
		else $error("lane_walker: byte strobe with no lane pending");

endmodule

`default_nettype wire

//--- logic/byte_ram.sv
/* byte wide ram on the narrow bus. writes on the strobe edge and returns
   read data registered one cycle after the strobe. */

`default_nettype none

module byte_ram #(
	parameter int ARCHBITSZ = 32,
	parameter int RAMBYTES = 256, // depth, power of two.
	localparam int AW = $clog2(RAMBYTES) // decoded address bits.
) (
	input  logic clk_i,
	input  logic stb_i, // one access per strobe.
	input  logic we_i,
	input  logic [ARCHBITSZ-1:0] addr_i, // byte address, upper bits alias.
	input  narrow_pkg::byte_t wdata_i,
	output narrow_pkg::byte_t rdata_o
);

	// ####################
	// depth check
	// ####################

	if (RAMBYTES < 2 || (RAMBYTES & (RAMBYTES - 1)) != 0) begin : g_bad_depth
		$error("byte_ram: RAMBYTES %0d is not a power of two", RAMBYTES);
	end

	// ####################
	// storage
	// ####################

	narrow_pkg::byte_t mem [RAMBYTES]; // contents undefined until written.
	logic [AW-1:0] idx; // decoded part of the byte address.

	assign idx = addr_i[AW-1:0];

	always_ff @(posedge clk_i) begin
		if (stb_i) begin
			if (we_i) begin
				mem[idx] <= wdata_i; // store on the strobe edge.
			end else begin
				rdata_o <= mem[idx]; // visible the following cycle.
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/narrow_bridge_top.sv
/* wide-to-narrow adapter top, cpu word port in, byte ram behind it.
   wires the lane walker, the byte address block and the ram. */

`default_nettype none

module narrow_bridge_top #(
	parameter int ARCHBITSZ = 32, // cpu word width.
	parameter int RAMBYTES = 256, // byte ram depth.
	localparam int SELW = ARCHBITSZ / 8,
	localparam int LANEW = $clog2(SELW),
	localparam int ADDRW = ARCHBITSZ - LANEW
) (
	input  logic clk_i,
	input  logic reset_i,
	input  logic req_i,
	input  logic we_i,
	input  logic [ADDRW-1:0] waddr_i,
	input  logic [SELW-1:0] sel_i,
	input  logic [ARCHBITSZ-1:0] wdata_i,
	output logic busy_o,
	output logic done_o,
	output logic [ARCHBITSZ-1:0] rdata_o
);

	// ####################
	// width check
	// ####################

	if (ARCHBITSZ < 16 || ARCHBITSZ > narrow_pkg::MAX_ARCHBITSZ
		|| (ARCHBITSZ & (ARCHBITSZ - 1)) != 0) begin : g_bad_width
		$error("narrow_bridge_top: unsupported ARCHBITSZ %0d", ARCHBITSZ);
	end

	// ####################
	// interconnect
	// ####################

	logic [SELW-1:0] pend; // walker -> address block.
	logic [ADDRW-1:0] waddr_cap;
	logic [ARCHBITSZ-1:0] lane_addr; // address block -> walker.
	logic bstb; // narrow bus.
	logic bwe;
	logic [ARCHBITSZ-1:0] baddr;
	narrow_pkg::byte_t bwdata;
	narrow_pkg::byte_t brdata;

	lane_walker #(.ARCHBITSZ(ARCHBITSZ)) i_walker (
		.clk_i(clk_i), .reset_i(reset_i), .req_i(req_i), .we_i(we_i),
		.waddr_i(waddr_i), .sel_i(sel_i), .wdata_i(wdata_i),
		.busy_o(busy_o), .done_o(done_o), .rdata_o(rdata_o),
		.pend_o(pend), .waddr_o(waddr_cap), .baddr_i(lane_addr),
		.bstb_o(bstb), .bwe_o(bwe), .baddr_o(baddr),
		.bwdata_o(bwdata), .brdata_i(brdata)
	);

	byte_addr #(.ARCHBITSZ(ARCHBITSZ)) i_addr (
		.addr_i(waddr_cap), .sel_i(pend), .addr_o(lane_addr)
	);

	byte_ram #(.ARCHBITSZ(ARCHBITSZ), .RAMBYTES(RAMBYTES)) i_ram (
		.clk_i(clk_i), .stb_i(bstb), .we_i(bwe), .addr_i(baddr),
		.wdata_i(bwdata), .rdata_o(brdata)
	);

endmodule

`default_nettype wire

//--- verification/narrow_bridge_tb.sv
/* table driven testbench for the narrow bridge, checked against a byte array model.
   built from src.f by the Makefile in the project root. */

`default_nettype none

module narrow_bridge_tb;

	localparam int ARCHBITSZ = 32;
	localparam int RAMBYTES = 256;
	localparam int SELW = ARCHBITSZ / 8;
	localparam int ADDRW = ARCHBITSZ - $clog2(SELW);
	localparam int CLK_PERIOD = 40;
	localparam int N_RAND = 60; // random entries after the directed ones.

	typedef logic [ARCHBITSZ-1:0] word_t;
	typedef logic [SELW-1:0] sel_t;
	typedef logic [ADDRW-1:0] waddr_t;

	// one request and what it must return.
	typedef struct packed {
		logic we;
		waddr_t addr;
		sel_t sel;
		word_t data;
		word_t exp; // expected rdata_o at done.
		logic [3:0] cycles; // edges from request to done.
	} entry_t;

	logic clk;
	logic reset_i;
	logic req_i;
	logic we_i;
	waddr_t waddr_i;
	sel_t sel_i;
	word_t wdata_i;
	logic busy_o;
	logic done_o;
	word_t rdata_o;

	entry_t table_q[$];
	narrow_pkg::byte_t model_mem [RAMBYTES]; // reference copy of the ram.
	integer seed = 28511;
	int errors = 0;
	int checks = 0;
	logic table_done = 1'b0;

	narrow_bridge_top #(.ARCHBITSZ(ARCHBITSZ), .RAMBYTES(RAMBYTES)) i_dut (
		.clk_i(clk), .reset_i(reset_i), .req_i(req_i), .we_i(we_i),
		.waddr_i(waddr_i), .sel_i(sel_i), .wdata_i(wdata_i),
		.busy_o(busy_o), .done_o(done_o), .rdata_o(rdata_o)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// ####################
	// compare
	// ####################

	task automatic check_word(input word_t got, input word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED t=%0t %s: got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED t=%0t %s: got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAILED t=%0t %s: got %0d edges expected %0d", $time, what, got, exp);
		end
	endtask

	// ####################
	// table and model
	// ####################

	task automatic add_entry(input logic we, input waddr_t addr, input sel_t sel,
		input word_t data);
		entry_t e;
		e = '0;
		e.we = we;
		e.addr = addr;
		e.sel = sel;
		e.data = data;
		table_q.push_back(e);
	endtask

	function automatic int count_lanes(input sel_t sel);
		int n;
		n = 0;
		for (int l = 0; l < SELW; l++) begin
			if (sel[l]) n++;
		end
		return n;
	endfunction

	// run the model over the table in order and fill the expected columns.
	task automatic predict_table();
		logic [7:0] baddr;
		for (int i = 0; i < table_q.size(); i++) begin
			table_q[i].exp = '0; // writes return a cleared word.
			table_q[i].cycles = 4'(count_lanes(table_q[i].sel) + 2);
			for (int l = 0; l < SELW; l++) begin
				baddr = 8'(table_q[i].addr * SELW + l); // low bits only, upper ones alias.
				if (table_q[i].sel[l] && table_q[i].we) begin
					model_mem[baddr] = table_q[i].data[l*8 +: 8];
				end else if (table_q[i].sel[l]) begin
					table_q[i].exp[l*8 +: 8] = model_mem[baddr];
				end
			end
		end
	endtask

	task automatic build_table();
		word_t fill;
		for (int w = 0; w < RAMBYTES / SELW; w++) begin // whole ram written first.
			for (int l = 0; l < SELW; l++) begin
				fill[l*8 +: 8] = 8'((w * SELW + l) * 37 + 11); // odd multiplier, all bytes differ.
			end
			add_entry(1'b1, waddr_t'(w), 4'b1111, fill);
		end
		add_entry(1'b1, 30'd5, 4'b1111, 32'ha1b2c3d4); // full write then read back.
		add_entry(1'b0, 30'd5, 4'b1111, 32'h0);
		add_entry(1'b1, 30'd5, 4'b0110, 32'h11223344); // middle bytes only.
		add_entry(1'b0, 30'd5, 4'b1111, 32'h0);
		add_entry(1'b1, 30'd9, 4'b0101, 32'hcafebabe); // split lanes.
		add_entry(1'b0, 30'd9, 4'b1010, 32'h0);
		add_entry(1'b0, 30'd9, 4'b0101, 32'h0);
		add_entry(1'b1, 30'd9, 4'b0000, 32'hffffffff); // empty select, no access.
		add_entry(1'b0, 30'd9, 4'b0000, 32'h0);
		add_entry(1'b0, 30'd9, 4'b1111, 32'h0);
		for (int i = 0; i < N_RAND; i++) begin
			add_entry(1'($random(seed)), waddr_t'($random(seed)), sel_t'($random(seed)),
				word_t'($random(seed)));
		end
		predict_table();
	endtask

	// ####################
	// apply
	// ####################

	// called on a falling edge, returns one idle cycle after done.
	task automatic run_entry(input int idx);
		entry_t e;
		int cyc;
		int errs_before;
		e = table_q[idx];
		errs_before = errors;
		req_i = 1'b1;
		we_i = e.we;
		waddr_i = e.addr;
		sel_i = e.sel;
		wdata_i = e.data;
		@(negedge clk);
		req_i = 1'b0;
		cyc = 1; // edge that closes this cycle, counted from the request edge.
		while (done_o !== 1'b1) begin
			check_bit(busy_o, 1'b1, $sformatf("entry %0d busy_o during walk", idx));
			@(negedge clk);
			cyc++;
		end
		check_count(cyc, int'(e.cycles), $sformatf("entry %0d done_o timing", idx));
		check_bit(busy_o, 1'b0, $sformatf("entry %0d busy_o at done", idx));
		check_word(rdata_o, e.exp, $sformatf("entry %0d rdata_o", idx));
		@(negedge clk);
		check_bit(done_o, 1'b0, $sformatf("entry %0d done_o width", idx)); // one cycle strobe.
		check_word(rdata_o, e.exp, $sformatf("entry %0d rdata_o held", idx));
		$display("entry %0d %s waddr=%h sel=%b edges=%0d %s", idx, e.we ? "write" : "read",
			e.addr, e.sel, cyc, (errors == errs_before) ? "ok" : "mismatch");
	endtask

	initial begin
		reset_i = 1'b1;
		req_i = 1'b0;
		we_i = 1'b0;
		waddr_i = '0;
		sel_i = '0;
		wdata_i = '0;
		build_table();
		table_done = 1'b1;
		repeat (3) @(negedge clk);
		reset_i = 1'b0;
		for (int i = 0; i < 3; i++) begin // quiet bus, nothing may move.
			@(negedge clk);
			check_bit(busy_o, 1'b0, "busy_o idle after reset");
			check_bit(done_o, 1'b0, "done_o idle after reset");
		end
		for (int i = 0; i < table_q.size(); i++) begin
			run_entry(i);
		end
		$display("entries %0d, checks %0d, errors %0d", table_q.size(), checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// ####################
	// watchdog
	// ####################

	initial begin
		narrow_pkg::walker_state_e st;
		wait (table_done);
		#((table_q.size() * 8 + 20) * CLK_PERIOD); // eight cycles per entry is ample.
		st = i_dut.i_walker.state_q;
		$display("watchdog expired at t=%0t, done_o never came, walker in %s", $time,
			st.name());
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
logic/narrow_pkg.sv
logic/byte_addr.sv
logic/lane_walker.sv
logic/byte_ram.sv
logic/narrow_bridge_top.sv
verification/narrow_bridge_tb.sv

//--- Makefile
# Verilator build and run of the narrow bridge testbench.

VERILATOR ?= verilator
TOP       ?= narrow_bridge_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

FILELIST  := src.f
SRCS      := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

PASS_MSG  := Done: no errors
FAIL_MSG  := Done: errors found

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation did not finish, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
